//--- all.f
hw/asg_pkg.sv
hw/asg_regs.sv
hw/asg_buf.sv
hw/asg_core.sv
hw/asg_lin.sv
hw/asg_top.sv
tb/asg_tb.sv

//--- Makefile
# Verilator build and run of the ASG testbench

TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP   = asg_tb
FILES = all.f

.PHONY: sim clean

# build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb/asg_tb.sv
////////////////////
// testbench for asg_top with random stimulus from seed 16
// expected samples come from a behavioral model of table, pointer and gain/offset
// first mismatch ends the run
////////////////////

module asg_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUS_OPS = 1400;  // planned bus strobes
  localparam int SMP_CNT = 700;   // planned output samples
  localparam int LIMIT   = BUS_OPS * 4 + SMP_CNT * 8 + 2000;

  // control word bits as the bus sees them
  localparam logic [31:0] CTL_RST = 32'h1;
  localparam logic [31:0] CTL_TRG = 32'h2;
  localparam logic [31:0] STS_RUN = 32'h4;
  localparam logic [31:0] STS_STP = 32'h8;

  localparam logic [11:0] CFG_LIST [0:9] = '{
    asg_pkg::REG_TRG, asg_pkg::REG_SIZ, asg_pkg::REG_OFF, asg_pkg::REG_STP,
    asg_pkg::REG_BST, asg_pkg::REG_BDL, asg_pkg::REG_BLN, asg_pkg::REG_BNM,
    asg_pkg::REG_MUL, asg_pkg::REG_SUM
  };

  logic        bus = 1'b0;
  logic        rst;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_wen;
  logic        bus_ren;
  logic [31:0] bus_rdata;
  logic        bus_ack;
  logic        bus_err;
  logic [3:0]  trg_ext;
  logic        trg_swo;
  logic        trg_out;
  logic        irq_trg;
  logic        irq_stp;
  logic [13:0] sto_data;
  logic        sto_valid;
  logic        sto_ready;

  integer      seed;
  int          cycles = 0;
  int          beats = 0;      // sto transfers seen
  int          n_trg = 0;      // irq_trg pulses
  int          n_out = 0;      // trg_out pulses
  int          n_stp = 0;      // irq_stp pulses
  int          n_swo = 0;      // trg_swo pulses
  logic        rnd_ready = 1'b0;
  logic        rdy_bit = 1'b1;  // next random ready
  logic [31:0] shadow [0:15];  // register mirror, word indexed
  logic [13:0] table_sh [0:1023];
  logic [13:0] exp_q [$];      // model output in arrival order

  asg_top asg_top_i (
    .bus, .rst,
    .bus_addr, .bus_wdata, .bus_wen, .bus_ren, .bus_rdata, .bus_ack, .bus_err,
    .trg_ext, .trg_swo, .trg_out, .irq_trg, .irq_stp,
    .sto_data, .sto_valid, .sto_ready
  );

  always #10 bus = ~bus;  // 20 ns period

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  always @(posedge bus) begin
    cycles = cycles + 1;
    assert (cycles <= LIMIT) else stop_on_error("timeout, the tests did not finish in time");
  end

  // trg_swo follows the bus strobe and is counted at the rising edge
  always @(posedge bus) begin : edge_sampler
    logic [31:0] r;
    r = $random(seed);
    rdy_bit = r[0];
    if (trg_swo) n_swo = n_swo + 1;
  end

  ////////////////////
  // stream sink and event counters
  ////////////////////

  always @(negedge bus) begin : stream_monitor
    logic [13:0] exp_smp;
    sto_ready = rnd_ready ? rdy_bit : 1'b1;  // random back-pressure when enabled
    if (irq_trg) n_trg = n_trg + 1;
    if (trg_out) n_out = n_out + 1;
    if (irq_stp) n_stp = n_stp + 1;
    if (sto_valid && sto_ready) begin  // transfer at the coming edge
      assert (exp_q.size() != 0) else stop_on_error("sto beat arrived with no sample expected");
      exp_smp = exp_q.pop_front();
      assert (sto_data == exp_smp) else
        stop_on_error($sformatf("error: sto_data = %h, expected %h", sto_data, exp_smp));
      beats = beats + 1;
    end
  end

  // model helpers
  function automatic logic [31:0] width_mask(input int w);
    return 32'hffff_ffff >> (32 - w);
  endfunction

  function automatic logic [31:0] reg_mask(input logic [11:0] ofs);
    case (ofs)
      asg_pkg::REG_TRG:                                     return width_mask(asg_pkg::TN);
      asg_pkg::REG_SIZ, asg_pkg::REG_OFF, asg_pkg::REG_STP: return width_mask(asg_pkg::CW);
      asg_pkg::REG_BST:                                     return 32'h3;  // ben and inf
      asg_pkg::REG_BDL:                                     return width_mask(asg_pkg::CWM);
      asg_pkg::REG_BLN:                                     return width_mask(asg_pkg::CWL);
      asg_pkg::REG_BNM:                                     return width_mask(asg_pkg::CWN);
      asg_pkg::REG_MUL, asg_pkg::REG_SUM:                   return width_mask(asg_pkg::DW);
      default:                                              return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] cfg_val(input logic [11:0] ofs);
    return shadow[ofs[5:2]];
  endfunction

  function automatic int to_int(input logic [13:0] x);
    int v;
    v = {18'd0, x};
    if (x[asg_pkg::DW-1]) v = v - (1 << asg_pkg::DW);  // two's complement
    return v;
  endfunction

  function automatic int clamp(input int v);
    int mx;
    mx = (1 << (asg_pkg::DW - 1)) - 1;
    if (v > mx) return mx;
    if (v < -mx - 1) return -mx - 1;
    return v;
  endfunction

  // gain then offset, each saturating
  function automatic logic [13:0] lin_model(input logic [13:0] smp);
    logic [31:0] mul;
    logic [31:0] sum;
    int          v;
    mul = cfg_val(asg_pkg::REG_MUL);
    sum = cfg_val(asg_pkg::REG_SUM);
    v = to_int(smp) * to_int(mul[13:0]);
    v = clamp(v >>> asg_pkg::GAIN_SHIFT);
    v = clamp(v + to_int(sum[13:0]));
    return v[asg_pkg::DW-1:0];
  endfunction

  ////////////////////
  // bus master
  ////////////////////

  task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(negedge bus);
    assert (!bus_ack) else stop_on_error("bus ack was high before the strobe");
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_wen   = wr;
    bus_ren   = ~wr;
    @(negedge bus);  // ack due one cycle later
    assert (bus_ack) else
      stop_on_error($sformatf("no bus ack one cycle after the strobe at address %h", addr));
    assert (!bus_err) else stop_on_error("bus err was raised");
    rdata   = bus_rdata;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
  endtask

  task automatic reg_write(input logic [11:0] ofs, input logic [31:0] data);
    logic [31:0] dummy;
    bus_cycle(1'b1, {20'd0, ofs}, data, dummy);
    shadow[ofs[5:2]] = data & reg_mask(ofs);
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_val);
    logic [31:0] rd;
    bus_cycle(1'b0, addr, 32'h0, rd);
    assert (rd == exp_val) else
      stop_on_error($sformatf("error: bus_rdata at %h = %h, expected %h", addr, rd, exp_val));
  endtask

  // software trigger through the control word
  task automatic sw_trigger();
    int swo0;
    swo0 = n_swo;
    reg_write(asg_pkg::REG_CTL, CTL_TRG);
    assert (n_swo == swo0 + 1) else
      stop_on_error("trg_swo did not pulse once for the software trigger");
  endtask

  // random wave shape, step and offset below siz
  task automatic pick_wave();
    logic [31:0] r;
    logic [31:0] siz;
    logic [31:0] stp;
    r = $random(seed);
    siz = {6'd0, r[25:0]};
    if (siz < 32'h0008_0000) siz = siz + 32'h0008_0000;  // at least 8 samples
    reg_write(asg_pkg::REG_SIZ, siz);
    r = $random(seed);
    reg_write(asg_pkg::REG_OFF, {6'd0, r[25:0]} % siz);
    r = $random(seed);
    stp = {10'd0, r[21:0]} % siz;
    if (stp == 32'd0) stp = 32'd1;
    reg_write(asg_pkg::REG_STP, stp);
  endtask

  // wrapped fixed point sequence from off
  task automatic expect_cont(input int n);
    logic [31:0] p;
    p = cfg_val(asg_pkg::REG_OFF);
    repeat (n) begin
      exp_q.push_back(lin_model(table_sh[p[asg_pkg::CW-1:asg_pkg::CWF]]));
      p = p + cfg_val(asg_pkg::REG_STP);
      if (p >= cfg_val(asg_pkg::REG_SIZ)) p = p - cfg_val(asg_pkg::REG_SIZ);
    end
  endtask

  // bdl+1 table samples then bln zeros in every burst
  task automatic expect_burst();
    logic [31:0] p;
    int          bnm;
    int          bdl;
    int          bln;
    bnm = cfg_val(asg_pkg::REG_BNM);
    bdl = cfg_val(asg_pkg::REG_BDL);
    bln = cfg_val(asg_pkg::REG_BLN);
    for (int b = 0; b < bnm; b++) begin
      p = cfg_val(asg_pkg::REG_OFF);  // each burst restarts here
      for (int i = 0; i <= bdl; i++) begin
        exp_q.push_back(lin_model(table_sh[p[asg_pkg::CW-1:asg_pkg::CWF]]));
        p = p + cfg_val(asg_pkg::REG_STP);
        if (p >= cfg_val(asg_pkg::REG_SIZ)) p = p - cfg_val(asg_pkg::REG_SIZ);
      end
      repeat (bln) exp_q.push_back(lin_model(14'd0));
    end
  endtask

  // ready high until the stream has been empty a few cycles
  task automatic drain();
    int idle;
    rnd_ready = 1'b0;
    idle = 0;
    while (idle < 4) begin
      @(negedge bus);
      if (sto_valid) idle = 0;
      else           idle = idle + 1;
    end
  endtask

  task automatic wait_empty();
    while (exp_q.size() != 0) @(negedge bus);
  endtask

  // sw trigger then n beats then a stop by control reset
  task automatic run_cont(input int n);
    int first;
    int swo0;
    exp_q.delete();
    expect_cont(n + 16);  // spare for samples in flight at the stop
    first = beats;
    rnd_ready = 1'b1;
    sw_trigger();
    while (beats - first < n) @(negedge bus);
    read_check({20'd0, asg_pkg::REG_CTL}, STS_RUN);
    swo0 = n_swo;
    reg_write(asg_pkg::REG_CTL, CTL_RST);
    assert (n_swo == swo0) else stop_on_error("trg_swo pulsed on a control reset");
    read_check({20'd0, asg_pkg::REG_CTL}, STS_STP);
    drain();
    exp_q.delete();  // anything later is flagged by the monitor
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : main
    logic [31:0] r;
    logic [9:0]  idx;
    int          stp0;
    int          trg0;
    int          out0;
    seed      = 16;
    rst       = 1'b1;
    bus_addr  = 32'h0;
    bus_wdata = 32'h0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    trg_ext   = 4'b0000;
    sto_ready = 1'b1;
    for (int i = 0; i < 16; i++) shadow[i] = 32'h0;
    repeat (8) @(negedge bus);
    rst = 1'b0;

    // 1. register readback and unmapped offsets
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 10; i++) begin
        r = $random(seed);
        reg_write(CFG_LIST[i], r);
      end
      for (int i = 0; i < 10; i++) read_check({20'd0, CFG_LIST[i]}, cfg_val(CFG_LIST[i]));
    end
    read_check({20'd0, asg_pkg::REG_STS_BLN}, 32'h0);
    read_check({20'd0, asg_pkg::REG_STS_BNM}, 32'h0);
    read_check(32'h008, 32'h0);
    read_check(32'h00c, 32'h0);
    read_check(32'h01c, 32'h0);
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      read_check({20'd0, r[11:2], 2'b00} | 32'h040, 32'h0);
    end

    // 2. table fill and a sign extended random readback
    for (int i = 0; i < 1024; i++) begin
      r = $random(seed);
      idx = i[9:0];
      table_sh[i] = r[13:0];
      bus_cycle(1'b1, (32'd1 << asg_pkg::BUF_SEL) | {20'd0, idx, 2'b00}, r, r);
    end
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      idx = r[9:0];
      read_check((32'd1 << asg_pkg::BUF_SEL) | {20'd0, idx, 2'b00},
                 {{18{table_sh[idx][13]}}, table_sh[idx]});
    end

    // 3. continuous mode at unity gain
    reg_write(asg_pkg::REG_BST, 32'h0);
    reg_write(asg_pkg::REG_MUL, 32'd1 << asg_pkg::GAIN_SHIFT);
    reg_write(asg_pkg::REG_SUM, 32'h0);
    for (int k = 0; k < 2; k++) begin
      pick_wave();
      run_cont(120);
    end

    // 4. gain and offset where the last two rounds saturate
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      if (k == 1) r = 32'h1c00_1fff;       // ~2x gain and a large positive offset
      else if (k == 2) r = 32'h2400_2001;  // ~-2x gain and a large negative offset
      reg_write(asg_pkg::REG_MUL, {18'd0, r[13:0]});
      reg_write(asg_pkg::REG_SUM, {18'd0, r[29:16]});
      run_cont(60);
    end

    // 5. bursts with random small sizes
    for (int k = 0; k < 2; k++) begin
      pick_wave();
      r = $random(seed);
      reg_write(asg_pkg::REG_BDL, {29'd0, r[2:0]});
      reg_write(asg_pkg::REG_BLN, {29'd0, r[6:4]});
      reg_write(asg_pkg::REG_BNM, {30'd0, r[9:8]} + 32'd1);
      reg_write(asg_pkg::REG_BST, 32'h1);  // ben without inf
      exp_q.delete();
      expect_burst();
      stp0 = n_stp;
      rnd_ready = 1'b1;
      sw_trigger();
      wait_empty();
      drain();
      assert (n_stp == stp0 + 1) else stop_on_error("irq_stp did not pulse exactly once");
      read_check({20'd0, asg_pkg::REG_STS_BNM}, cfg_val(asg_pkg::REG_BNM));
      read_check({20'd0, asg_pkg::REG_CTL}, STS_STP);
    end

    // 6. external trigger with the masked bit first
    pick_wave();
    r = $random(seed);
    reg_write(asg_pkg::REG_BDL, {29'd0, r[2:0]});
    reg_write(asg_pkg::REG_BLN, {30'd0, r[5:4]});
    reg_write(asg_pkg::REG_BNM, 32'h1);
    reg_write(asg_pkg::REG_TRG, 32'h5);  // bits 0 and 2 enabled
    exp_q.delete();
    trg0 = n_trg;
    out0 = n_out;
    @(negedge bus);
    trg_ext = 4'b0010;
    repeat (4) @(negedge bus);
    read_check({20'd0, asg_pkg::REG_CTL}, STS_STP);
    assert (n_trg == trg0 && n_out == out0) else
      stop_on_error("a masked trg_ext edge started the engine");
    expect_burst();
    @(negedge bus);
    trg_ext = 4'b0110;  // rising edge on bit 2
    wait_empty();
    drain();
    assert (n_trg == trg0 + 1) else stop_on_error("irq_trg did not pulse once for the edge");
    assert (n_out == out0 + 1) else stop_on_error("trg_out did not pulse once for the edge");
    trg_ext = 4'b0000;
    read_check({20'd0, asg_pkg::REG_CTL}, STS_STP);

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- hw/asg_top.sv
////////////////////
// single channel arbitrary waveform generator
// table at bus_addr bit 12 set, registers below
////////////////////

module asg_top (
  input  logic                    bus,
  input  logic                    rst,
  // system bus
  input  logic [31:0]             bus_addr,
  input  logic [31:0]             bus_wdata,
  input  logic                    bus_wen,
  input  logic                    bus_ren,
  output logic [31:0]             bus_rdata,
  output logic                    bus_ack,
  output logic                    bus_err,
  // triggers and interrupts
  input  logic [asg_pkg::TN-1:0]  trg_ext,
  output logic                    trg_swo,
  output logic                    trg_out,
  output logic                    irq_trg,
  output logic                    irq_stp,
  // sample stream out
  output logic [asg_pkg::DW-1:0]  sto_data,
  output logic                    sto_valid,
  input  logic                    sto_ready
);

  // table bus port
  logic                     buf_wen;
  logic                     buf_ren;
  logic [asg_pkg::CWM-1:0]  buf_addr;
  logic [asg_pkg::DW-1:0]   buf_wdata;
  logic [asg_pkg::DW-1:0]   buf_rdata;
  logic                     buf_ack;
  // engine read port
  logic [asg_pkg::CWM-1:0]  rd_addr;
  logic [asg_pkg::DW-1:0]   rd_data;
  // configuration and status
  logic                     ctl_rst;
  logic [asg_pkg::TN-1:0]   cfg_trg;
  logic [asg_pkg::CW-1:0]   cfg_siz;
  logic [asg_pkg::CW-1:0]   cfg_off;
  logic [asg_pkg::CW-1:0]   cfg_stp;
  logic                     cfg_ben;
  logic                     cfg_inf;
  logic [asg_pkg::CWM-1:0]  cfg_bdl;
  logic [asg_pkg::CWL-1:0]  cfg_bln;
  logic [asg_pkg::CWN-1:0]  cfg_bnm;
  logic [asg_pkg::DW-1:0]   cfg_mul;
  logic [asg_pkg::DW-1:0]   cfg_sum;
  logic                     sts_run;
  logic [asg_pkg::CWL-1:0]  sts_bln;
  logic [asg_pkg::CWN-1:0]  sts_bnm;
  // core to lin stream
  logic [asg_pkg::DW-1:0]   smp_data;
  logic                     smp_valid;
  logic                     smp_ready;

  asg_regs asg_regs_i (
    .bus, .rst,
    .bus_addr, .bus_wdata, .bus_wen, .bus_ren, .bus_rdata, .bus_ack, .bus_err,
    .buf_wen, .buf_ren, .buf_addr, .buf_wdata, .buf_rdata, .buf_ack,
    .ctl_rst, .trg_swo,
    .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp,
    .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bln, .cfg_bnm,
    .cfg_mul, .cfg_sum,
    .sts_run, .sts_bln, .sts_bnm
  );

  asg_buf asg_buf_i (
    .bus,
    .buf_wen, .buf_ren, .buf_addr, .buf_wdata, .buf_rdata, .buf_ack,
    .rd_addr, .rd_data
  );

  asg_core asg_core_i (
    .bus, .rst, .ctl_rst, .trg_swo, .trg_ext,
    .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp,
    .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bln, .cfg_bnm,
    .rd_addr, .rd_data,
    .smp_data, .smp_valid, .smp_ready,
    .trg_out, .irq_trg, .irq_stp,
    .sts_run, .sts_bln, .sts_bnm
  );

  asg_lin asg_lin_i (
    .bus, .rst,
    .smp_data, .smp_valid, .smp_ready,
    .cfg_mul, .cfg_sum,
    .sto_data, .sto_valid, .sto_ready
  );

endmodule

//--- hw/asg_lin.sv
////////////////////
// gain then offset, both saturate to the 14 bit signed range
// two registered stages with valid/ready back-pressure
////////////////////

module asg_lin (
  input  logic                    bus,
  input  logic                    rst,
  input  logic [asg_pkg::DW-1:0]  smp_data,
  input  logic                    smp_valid,
  output logic                    smp_ready,
  input  logic [asg_pkg::DW-1:0]  cfg_mul,
  input  logic [asg_pkg::DW-1:0]  cfg_sum,
  output logic [asg_pkg::DW-1:0]  sto_data,
  output logic                    sto_valid,
  input  logic                    sto_ready
);

  logic signed [2*asg_pkg::DW-1:0] mul_prd;   // full product
  logic signed [2*asg_pkg::DW-1:0] mul_shf;   // scaled by gain unit
  logic signed [2*asg_pkg::DW-1:0] add_sum;
  logic        [asg_pkg::DW-1:0]   s1_dat;
  logic                            s1_vld;
  logic                            s2_rdy;

  // clamp a wide signed value into DW bits
  function automatic logic [asg_pkg::DW-1:0] sat(input logic signed [2*asg_pkg::DW-1:0] x);
    logic [asg_pkg::DW:0] top;
    top = x[2*asg_pkg::DW-1:asg_pkg::DW-1];
    if ((&top) || ~(|top)) return x[asg_pkg::DW-1:0];  // fits
    return {x[2*asg_pkg::DW-1], {(asg_pkg::DW-1){~x[2*asg_pkg::DW-1]}}};
  endfunction

  assign mul_prd = $signed(smp_data) * $signed(cfg_mul);
  assign mul_shf = mul_prd >>> asg_pkg::GAIN_SHIFT;  // arithmetic
  assign add_sum = $signed(s1_dat) + $signed(cfg_sum);

  // a stage takes new data when empty or draining
  assign s2_rdy    = ~sto_valid | sto_ready;
  assign smp_ready = ~s1_vld | s2_rdy;

  ////////////////////
  // stage valids
  ////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      s1_vld    <= 1'b0;
      sto_valid <= 1'b0;
    end else begin
      if (smp_ready) s1_vld    <= smp_valid;
      if (s2_rdy)    sto_valid <= s1_vld;
    end
  end

  // payloads
  always_ff @(posedge bus) begin
    if (smp_ready & smp_valid) s1_dat   <= sat(mul_shf);  // gain
    if (s2_rdy & s1_vld)       sto_data <= sat(add_sum);  // offset
  end

endmodule

//--- hw/asg_core.sv
////////////////////
// generator engine: trigger, phase pointer, bursts, sample stream
// triggers are ignored while running
// ctl_rst stops the engine, a sample already on the stream still leaves
////////////////////

module asg_core (
  input  logic                     bus,
  input  logic                     rst,
  input  logic                     ctl_rst,
  input  logic                     trg_swo,
  input  logic [asg_pkg::TN-1:0]   trg_ext,
  // configuration
  input  logic [asg_pkg::TN-1:0]   cfg_trg,
  input  logic [asg_pkg::CW-1:0]   cfg_siz,
  input  logic [asg_pkg::CW-1:0]   cfg_off,
  input  logic [asg_pkg::CW-1:0]   cfg_stp,
  input  logic                     cfg_ben,
  input  logic                     cfg_inf,
  input  logic [asg_pkg::CWM-1:0]  cfg_bdl,
  input  logic [asg_pkg::CWL-1:0]  cfg_bln,
  input  logic [asg_pkg::CWN-1:0]  cfg_bnm,
  // table
  output logic [asg_pkg::CWM-1:0]  rd_addr,
  input  logic [asg_pkg::DW-1:0]   rd_data,
  // stream
  output logic [asg_pkg::DW-1:0]   smp_data,
  output logic                     smp_valid,
  input  logic                     smp_ready,
  // events and status
  output logic                     trg_out,
  output logic                     irq_trg,
  output logic                     irq_stp,
  output logic                     sts_run,
  output logic [asg_pkg::CWL-1:0]  sts_bln,
  output logic [asg_pkg::CWN-1:0]  sts_bnm
);

  logic [asg_pkg::TN-1:0]   trg_ext_r;  // previous trg_ext for edge detect
  logic                     run;
  logic [asg_pkg::CW-1:0]   ptr;        // fixed point table pointer
  logic [asg_pkg::CW-1:0]   ptr_d;      // pointer for next cycle
  logic [asg_pkg::CW:0]     ptr_sum;    // one extra bit for the wrap compare
  logic [asg_pkg::CWL:0]    bst_top;    // last sample index within a burst
  logic                     start;
  logic                     accept;     // output register takes a sample
  logic                     bst_dat;    // current sample comes from the table
  logic                     bst_end;    // current sample closes the burst
  logic                     bst_last;   // ... and it was the final burst

  assign start  = ~run & (trg_swo | (|(trg_ext & ~trg_ext_r & cfg_trg)));
  assign accept = run & (~smp_valid | smp_ready);

  ////////////////////
  // burst bookkeeping
  ////////////////////

  assign bst_top  = {{(asg_pkg::CWL+1-asg_pkg::CWM){1'b0}}, cfg_bdl} + {1'b0, cfg_bln};
  assign bst_dat  = ~cfg_ben
                  | (sts_bln <= {{(asg_pkg::CWL-asg_pkg::CWM){1'b0}}, cfg_bdl});
  assign bst_end  = cfg_ben & ({1'b0, sts_bln} == bst_top);
  assign bst_last = bst_end & ~cfg_inf & (sts_bnm + 1'b1 == cfg_bnm);

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_stp};

  // pointer update, wraps at table size
  always_comb begin
    ptr_d = ptr;
    if (start) begin
      ptr_d = cfg_off;
    end else if (accept) begin
      if (bst_end) begin
        ptr_d = cfg_off;  // next burst restarts at offset
      end else if (bst_dat) begin
        if (ptr_sum >= {1'b0, cfg_siz}) ptr_d = asg_pkg::CW'(ptr_sum - {1'b0, cfg_siz});
        else                            ptr_d = ptr_sum[asg_pkg::CW-1:0];
      end
    end
  end

  // address leads the pointer so rd_data always matches ptr
  assign rd_addr = ptr_d[asg_pkg::CW-1:asg_pkg::CWF];

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      trg_ext_r <= '0;
      run       <= 1'b0;
      ptr       <= '0;
      sts_bln   <= '0;
      sts_bnm   <= '0;
      smp_valid <= 1'b0;
      trg_out   <= 1'b0;
      irq_trg   <= 1'b0;
      irq_stp   <= 1'b0;
    end else begin
      trg_ext_r <= trg_ext;
      ptr       <= ptr_d;
      trg_out   <= start;  // one cycle notification
      irq_trg   <= start;
      irq_stp   <= 1'b0;
      if (ctl_rst) begin
        run <= 1'b0;
      end else if (start) begin
        run     <= 1'b1;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (accept & cfg_ben) begin
        if (bst_end) begin
          sts_bln <= '0;
          sts_bnm <= sts_bnm + 1'b1;
          if (bst_last) begin
            run     <= 1'b0;
            irq_stp <= 1'b1;
          end
        end else begin
          sts_bln <= sts_bln + 1'b1;
        end
      end
      // valid holds until the lin stage takes it
      if (accept)         smp_valid <= 1'b1;
      else if (smp_ready) smp_valid <= 1'b0;
    end
  end

  // sample payload, zero during burst idle
  always_ff @(posedge bus) begin
    if (accept) smp_data <= bst_dat ? rd_data : '0;
  end

  assign sts_run = run;

endmodule

//--- hw/asg_buf.sv
////////////////////
// 1024 x 14 sample table, bus port and engine read port
// contents undefined until software fills them
////////////////////

module asg_buf (
  input  logic                     bus,
  // bus port
  input  logic                     buf_wen,
  input  logic                     buf_ren,
  input  logic [asg_pkg::CWM-1:0]  buf_addr,
  input  logic [asg_pkg::DW-1:0]   buf_wdata,
  output logic [asg_pkg::DW-1:0]   buf_rdata,
  output logic                     buf_ack,
  // engine port
  input  logic [asg_pkg::CWM-1:0]  rd_addr,
  output logic [asg_pkg::DW-1:0]   rd_data
);

  logic [asg_pkg::DW-1:0] mem [0:(2**asg_pkg::CWM)-1];

  // bus side read/write
  always_ff @(posedge bus) begin
    if (buf_wen) mem[buf_addr] <= buf_wdata;
    if (buf_ren) buf_rdata <= mem[buf_addr];
    buf_ack <= buf_wen | buf_ren;  // answer next cycle
  end

  // engine side, read every cycle
  always_ff @(posedge bus) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hw/asg_regs.sv
////////////////////
// system bus slave: config/status registers plus table window
// ack one cycle after strobe, err never set
// one strobe outstanding at a time
////////////////////

module asg_regs (
  input  logic                     bus,
  input  logic                     rst,
  input  logic [31:0]              bus_addr,
  input  logic [31:0]              bus_wdata,
  input  logic                     bus_wen,
  input  logic                     bus_ren,
  output logic [31:0]              bus_rdata,
  output logic                     bus_ack,
  output logic                     bus_err,
  // table side
  output logic                     buf_wen,
  output logic                     buf_ren,
  output logic [asg_pkg::CWM-1:0]  buf_addr,
  output logic [asg_pkg::DW-1:0]   buf_wdata,
  input  logic [asg_pkg::DW-1:0]   buf_rdata,
  input  logic                     buf_ack,
  // control pulses
  output logic                     ctl_rst,
  output logic                     trg_swo,
  // configuration
  output logic [asg_pkg::TN-1:0]   cfg_trg,
  output logic [asg_pkg::CW-1:0]   cfg_siz,
  output logic [asg_pkg::CW-1:0]   cfg_off,
  output logic [asg_pkg::CW-1:0]   cfg_stp,
  output logic                     cfg_ben,
  output logic                     cfg_inf,
  output logic [asg_pkg::CWM-1:0]  cfg_bdl,
  output logic [asg_pkg::CWL-1:0]  cfg_bln,
  output logic [asg_pkg::CWN-1:0]  cfg_bnm,
  output logic [asg_pkg::DW-1:0]   cfg_mul,
  output logic [asg_pkg::DW-1:0]   cfg_sum,
  // status
  input  logic                     sts_run,
  input  logic [asg_pkg::CWL-1:0]  sts_bln,
  input  logic [asg_pkg::CWN-1:0]  sts_bnm
);

  logic                          reg_sel;    // strobe hits register space
  logic [asg_pkg::BUF_SEL-1:0]   reg_ofs;    // byte offset in register space
  logic                          reg_wen;
  logic                          reg_ack;
  logic [31:0]                   reg_rdata;
  logic                          buf_sel_r;  // pending answer comes from table
  asg_pkg::ctl_word_t            ctl_wr;
  asg_pkg::ctl_word_t            ctl_rd;

  assign reg_sel = ~bus_addr[asg_pkg::BUF_SEL];
  assign reg_ofs = bus_addr[asg_pkg::BUF_SEL-1:0];
  assign reg_wen = bus_wen & reg_sel;

  // table window, word addressed
  assign buf_wen   = bus_wen & ~reg_sel;
  assign buf_ren   = bus_ren & ~reg_sel;
  assign buf_addr  = bus_addr[asg_pkg::BUF_SEL-1:2];
  assign buf_wdata = bus_wdata[asg_pkg::DW-1:0];

  ////////////////////
  // control pulses
  ////////////////////

  assign ctl_wr  = bus_wdata;
  assign ctl_rst = reg_wen & (reg_ofs == asg_pkg::REG_CTL) & ctl_wr.wr.rst;
  assign trg_swo = reg_wen & (reg_ofs == asg_pkg::REG_CTL) & ctl_wr.wr.trg;

  always_comb begin
    ctl_rd        = '0;
    ctl_rd.rd.run = sts_run;
    ctl_rd.rd.stp = ~sts_run;
  end

  // configuration writes
  always_ff @(posedge bus) begin
    if (rst) begin
      cfg_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_stp <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= '0;
      cfg_sum <= '0;
    end else if (reg_wen) begin
      case (reg_ofs)
        asg_pkg::REG_TRG: cfg_trg <= bus_wdata[asg_pkg::TN-1:0];
        asg_pkg::REG_SIZ: cfg_siz <= bus_wdata[asg_pkg::CW-1:0];
        asg_pkg::REG_OFF: cfg_off <= bus_wdata[asg_pkg::CW-1:0];
        asg_pkg::REG_STP: cfg_stp <= bus_wdata[asg_pkg::CW-1:0];
        asg_pkg::REG_BST: begin
          cfg_ben <= bus_wdata[0];
          cfg_inf <= bus_wdata[1];
        end
        asg_pkg::REG_BDL: cfg_bdl <= bus_wdata[asg_pkg::CWM-1:0];
        asg_pkg::REG_BLN: cfg_bln <= bus_wdata[asg_pkg::CWL-1:0];
        asg_pkg::REG_BNM: cfg_bnm <= bus_wdata[asg_pkg::CWN-1:0];
        asg_pkg::REG_MUL: cfg_mul <= bus_wdata[asg_pkg::DW-1:0];
        asg_pkg::REG_SUM: cfg_sum <= bus_wdata[asg_pkg::DW-1:0];
        default: ;  // status and unmapped are read only
      endcase
    end
  end

  // register read data, zero extended
  always_ff @(posedge bus) begin
    if (bus_ren & reg_sel) begin
      case (reg_ofs)
        asg_pkg::REG_CTL:     reg_rdata <= ctl_rd;
        asg_pkg::REG_TRG:     reg_rdata <= 32'(cfg_trg);
        asg_pkg::REG_SIZ:     reg_rdata <= 32'(cfg_siz);
        asg_pkg::REG_OFF:     reg_rdata <= 32'(cfg_off);
        asg_pkg::REG_STP:     reg_rdata <= 32'(cfg_stp);
        asg_pkg::REG_BST:     reg_rdata <= {30'd0, cfg_inf, cfg_ben};
        asg_pkg::REG_BDL:     reg_rdata <= 32'(cfg_bdl);
        asg_pkg::REG_BLN:     reg_rdata <= 32'(cfg_bln);
        asg_pkg::REG_BNM:     reg_rdata <= 32'(cfg_bnm);
        asg_pkg::REG_STS_BLN: reg_rdata <= 32'(sts_bln);
        asg_pkg::REG_STS_BNM: reg_rdata <= 32'(sts_bnm);
        asg_pkg::REG_MUL:     reg_rdata <= 32'(cfg_mul);
        asg_pkg::REG_SUM:     reg_rdata <= 32'(cfg_sum);
        default:              reg_rdata <= '0;
      endcase
    end
  end

  ////////////////////
  // answer select
  ////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      reg_ack   <= 1'b0;
      buf_sel_r <= 1'b0;
    end else begin
      reg_ack <= (bus_wen | bus_ren) & reg_sel;
      if (bus_wen | bus_ren) buf_sel_r <= ~reg_sel;  // remember who answers
    end
  end

  // table words come back sign extended
  assign bus_ack   = buf_sel_r ? buf_ack : reg_ack;
  assign bus_rdata = buf_sel_r ? {{(32-asg_pkg::DW){buf_rdata[asg_pkg::DW-1]}}, buf_rdata}
                               : reg_rdata;
  assign bus_err   = 1'b0;  // no error cases in this map

endmodule

//--- hw/asg_pkg.sv
////////////////////
// shared widths, register map and control word for the single channel ASG
// sample table is fixed at 1024 words of 14 bits
////////////////////

package asg_pkg;

  // data path and counters
  localparam int unsigned DW  = 14;         // sample width, signed
  localparam int unsigned CWM = 10;         // table address bits
  localparam int unsigned CWF = 16;         // phase fraction bits
  localparam int unsigned CW  = CWM + CWF;  // full pointer width
  localparam int unsigned CWL = 32;         // burst length counter
  localparam int unsigned CWN = 16;         // burst number counter
  localparam int unsigned TN  = 4;          // external triggers

  // gain of 2**GAIN_SHIFT is unity
  localparam int unsigned GAIN_SHIFT = DW - 2;

  ////////////////////
  // address map
  ////////////////////

  localparam int unsigned BUF_SEL = 12;  // high half of the 8 KB window is the table

  localparam logic [BUF_SEL-1:0] REG_CTL     = 12'h000;
  localparam logic [BUF_SEL-1:0] REG_TRG     = 12'h004;
  localparam logic [BUF_SEL-1:0] REG_SIZ     = 12'h010;
  localparam logic [BUF_SEL-1:0] REG_OFF     = 12'h014;
  localparam logic [BUF_SEL-1:0] REG_STP     = 12'h018;
  localparam logic [BUF_SEL-1:0] REG_BST     = 12'h020;  // ben bit 0, inf bit 1
  localparam logic [BUF_SEL-1:0] REG_BDL     = 12'h024;
  localparam logic [BUF_SEL-1:0] REG_BLN     = 12'h028;
  localparam logic [BUF_SEL-1:0] REG_BNM     = 12'h02c;
  localparam logic [BUF_SEL-1:0] REG_STS_BLN = 12'h030;
  localparam logic [BUF_SEL-1:0] REG_STS_BNM = 12'h034;
  localparam logic [BUF_SEL-1:0] REG_MUL     = 12'h038;
  localparam logic [BUF_SEL-1:0] REG_SUM     = 12'h03c;

  // control word, write side
  typedef struct packed {
    logic [29:0] rsv;
    logic        trg;  // software trigger pulse
    logic        rst;  // engine stop pulse
  } ctl_wr_t;

  // control word, read side
  typedef struct packed {
    logic [27:0] rsv;
    logic        stp;  // engine idle
    logic        run;  // engine running
    logic [1:0]  pad;
  } ctl_rd_t;

  typedef union packed {
    ctl_wr_t wr;
    ctl_rd_t rd;
  } ctl_word_t;

endpackage
